//--- logic/plru_pkg.sv
// Shared constants and types for the tree pseudo-LRU unit
// Way and tree bit vectors, set index, request and response structs
// Tree layout with node k having children 2k+1 (lower ways) and 2k+2 (upper ways)
package plru_pkg;

    // Cache geometry
    localparam int unsigned num_ways = 8;
    localparam int unsigned num_sets = 16;

    localparam int unsigned index_w = (num_sets > 1) ? $clog2(num_sets) : 1;
    localparam int unsigned tree_levels = $clog2(num_ways);

    // Associativity must be a power of two between 2 and 64
    localparam bit num_ways_ok = (num_ways >= 2) && (num_ways <= 64) &&
                                 (num_ways == (1 << tree_levels));

    // One bit per way
    typedef logic [num_ways-1:0] way_vec_t;

    // Tree bits of one set where a set bit means upper half used last
    typedef logic [num_ways-2:0] tree_t;

    typedef logic [index_w-1:0] index_t;

    typedef enum logic {
        op_hit   = 1'b0,
        op_evict = 1'b1
    } plru_op_e;

    typedef struct packed {
        plru_op_e op;
        index_t   index;
        way_vec_t hit_way;     // One-hot and used by hits only
        way_vec_t valid_tags;
        way_vec_t spm_lock;
        way_vec_t dirty_tags;
    } plru_req_t;

    typedef struct packed {
        plru_op_e op;
        way_vec_t way;
        logic     evict_dirty;
    } plru_rsp_t;

endpackage

//--- logic/plru_tree_store.sv
// Per-set storage of the pseudo-LRU tree bits
// Registered read with one cycle of latency, single write port
`timescale 1ns/1ps

module plru_tree_store
    import plru_pkg::*;
(
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  index_t rd_index_i,
    input  logic   wr_en_i,
    input  index_t wr_index_i,
    input  tree_t  wr_tree_i,
    output tree_t  rd_tree_o
);

    tree_t tree_mem [num_sets];

    // All sets start from the all-zero tree
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_mem[s] <= '0;
            end
        end else if (wr_en_i) begin
            tree_mem[wr_index_i] <= wr_tree_i;
        end
    end

    // Read word is captured every cycle
    always_ff @(posedge clk_i) begin
        rd_tree_o <= tree_mem[rd_index_i];
    end

endmodule

//--- logic/plru_hit_update.sv
// Tree update for a hit
// Every node on the path to the hit way is pointed at that way's half
`timescale 1ns/1ps

module plru_hit_update
    import plru_pkg::*;
(
    input  tree_t    tree_i,
    input  way_vec_t hit_way_i,
    output tree_t    tree_o
);

    for (genvar d = 0; d < tree_levels; d++) begin : g_level
        for (genvar p = 0; p < (1 << d); p++) begin : g_node
            // Node p of level d covers ways base .. base+2*half-1
            localparam int unsigned node = (1 << d) - 1 + p;
            localparam int unsigned half = num_ways >> (d + 1);
            localparam int unsigned base = p * 2 * half;

            logic hit_lo;
            logic hit_hi;

            assign hit_lo = |hit_way_i[base +: half];
            assign hit_hi = |hit_way_i[base + half +: half];

            // Nodes off the hit path keep their old value
            always_comb begin
                if (hit_hi) begin
                    tree_o[node] = 1'b1;
                end else if (hit_lo) begin
                    tree_o[node] = 1'b0;
                end else begin
                    tree_o[node] = tree_i[node];
                end
            end
        end
    end

endmodule

//--- logic/plru_victim_select.sv
// Victim choice for an eviction
// Candidate mask from free and locked ways, then a walk from the root
// Nodes on the walked path are updated to point at the victim
`timescale 1ns/1ps

module plru_victim_select
    import plru_pkg::*;
(
    input  tree_t    tree_i,
    input  way_vec_t valid_tags_i,
    input  way_vec_t spm_lock_i,
    output way_vec_t victim_o,
    output tree_t    tree_o
);

    way_vec_t free_ways;
    way_vec_t cand;
    tree_t    go_hi;

    assign free_ways = ~valid_tags_i & ~spm_lock_i;

    // Free unlocked ways win over occupied ones
    assign cand = (|free_ways) ? free_ways : ~spm_lock_i;

    // Direction every node would take if the walk reaches it
    for (genvar d = 0; d < tree_levels; d++) begin : g_level
        for (genvar p = 0; p < (1 << d); p++) begin : g_node
            localparam int unsigned node = (1 << d) - 1 + p;
            localparam int unsigned half = num_ways >> (d + 1);
            localparam int unsigned base = p * 2 * half;

            logic has_lo;
            logic has_hi;

            assign has_lo = |cand[base +: half];
            assign has_hi = |cand[base + half +: half];

            // With candidates on both sides go away from the recent half
            assign go_hi[node] = has_lo ? (has_hi & ~tree_i[node]) : 1'b1;
        end
    end

    always_comb begin : walk
        int unsigned node;

        tree_o = tree_i;
        node   = 0;
        for (int d = 0; d < tree_levels; d++) begin
            tree_o[node] = go_hi[node];
            node = 2 * node + 1 + int'(go_hi[node]);
        end

        // Leaf nodes are numbered after the num_ways-1 inner nodes
        victim_o = '0;
        victim_o[node - (num_ways - 1)] = 1'b1;
    end

endmodule

//--- logic/plru_ctrl.sv
// Request sequencer for the pseudo-LRU unit
// Idle, read and respond states, response build and tree write-back
// Interface checks on requests and on stalled responses
`timescale 1ns/1ps

module plru_ctrl
    import plru_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  plru_req_t req_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    output plru_rsp_t rsp_o,
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i,
    output index_t    rd_index_o,
    input  tree_t     rd_tree_i,
    output plru_req_t hold_req_o,
    output tree_t     hold_tree_o,
    input  tree_t     hit_tree_i,
    input  way_vec_t  victim_i,
    input  tree_t     victim_tree_i,
    output logic      wr_en_o,
    output index_t    wr_index_o,
    output tree_t     wr_tree_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_resp
    } state_e;

    state_e    state_q;
    state_e    state_d;
    plru_req_t req_q;
    tree_t     tree_q;
    logic      rsp_valid_q;
    logic      req_fire;
    logic      rsp_fire;
    logic      load_tree;
    logic      is_evict;

    if (!num_ways_ok) begin : g_ways_chk
        $error("num_ways must be a power of two from 2 to 64");
    end

    assign req_ready_o = (state_q == st_idle);
    assign req_fire    = req_valid_i & req_ready_o;
    assign rsp_fire    = rsp_valid_q & rsp_ready_i;

    // First respond cycle takes the store output
    assign load_tree = (state_q == st_resp) & ~rsp_valid_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (req_fire) state_d = st_read;
            st_read: state_d = st_resp;
            st_resp: if (rsp_fire) state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= st_idle;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (load_tree) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp_fire) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_q <= req_i;
        end
        if (load_tree) begin
            tree_q <= rd_tree_i;
        end
    end

    // Store index stays on the held set until the next request
    assign rd_index_o  = req_q.index;
    assign hold_req_o  = req_q;
    assign hold_tree_o = tree_q;

    assign is_evict = (req_q.op == op_evict);

    assign rsp_valid_o       = rsp_valid_q;
    assign rsp_o.op          = req_q.op;
    assign rsp_o.way         = is_evict ? victim_i : req_q.hit_way;
    assign rsp_o.evict_dirty = is_evict &
                               (|(victim_i & req_q.valid_tags & req_q.dirty_tags));

    // Tree write-back coincides with the response handshake
    assign wr_en_o    = rsp_fire;
    assign wr_index_o = req_q.index;
    assign wr_tree_o  = is_evict ? victim_tree_i : hit_tree_i;

    a_hit_onehot: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (req_fire && req_i.op == op_hit) |-> $onehot(req_i.hit_way)
    ) else $error("hit request without a one-hot hit_way");

    a_evict_unlocked: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (req_fire && req_i.op == op_evict) |-> !(&req_i.spm_lock)
    ) else $error("evict request with every way locked");

    // Held response must not move while the consumer stalls
    a_rsp_stable: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o))
    ) else $error("response changed while stalled");

endmodule

//--- logic/plru_top.sv
// Top level of the tree pseudo-LRU replacement unit
// Sequencer, tree bit store, hit update and victim selection
`timescale 1ns/1ps

module plru_top
    import plru_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  plru_req_t req_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    output plru_rsp_t rsp_o,
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i
);

    index_t    rd_index;
    tree_t     rd_tree;
    plru_req_t hold_req;
    tree_t     hold_tree;
    tree_t     hit_tree;
    way_vec_t  victim;
    tree_t     victim_tree;
    logic      wr_en;
    index_t    wr_index;
    tree_t     wr_tree;

    plru_ctrl u_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .rsp_o         (rsp_o),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_ready_i   (rsp_ready_i),
        .rd_index_o    (rd_index),
        .rd_tree_i     (rd_tree),
        .hold_req_o    (hold_req),
        .hold_tree_o   (hold_tree),
        .hit_tree_i    (hit_tree),
        .victim_i      (victim),
        .victim_tree_i (victim_tree),
        .wr_en_o       (wr_en),
        .wr_index_o    (wr_index),
        .wr_tree_o     (wr_tree)
    );

    plru_tree_store u_store (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rd_index_i (rd_index),
        .wr_en_i    (wr_en),
        .wr_index_i (wr_index),
        .wr_tree_i  (wr_tree),
        .rd_tree_o  (rd_tree)
    );

    plru_hit_update u_hit (
        .tree_i    (hold_tree),
        .hit_way_i (hold_req.hit_way),
        .tree_o    (hit_tree)
    );

    plru_victim_select u_victim (
        .tree_i       (hold_tree),
        .valid_tags_i (hold_req.valid_tags),
        .spm_lock_i   (hold_req.spm_lock),
        .victim_o     (victim),
        .tree_o       (victim_tree)
    );

endmodule

//--- include/plru_ref.svh
// Reference model of the pseudo-LRU tree for the testbench
// ref_hit gives the tree bits after a hit on a one-hot way
// ref_evict gives the victim way and tree bits after an eviction
`ifndef PLRU_REF_SVH
`define PLRU_REF_SVH

function automatic tree_t ref_hit(input tree_t tree, input way_vec_t hit_way);
    tree_t       t;
    int unsigned way;
    int unsigned node;
    int unsigned lo;
    int unsigned half;

    t    = tree;
    way  = 0;
    node = 0;
    lo   = 0;
    for (int i = 0; i < num_ways; i++) begin
        if (hit_way[i]) begin
            way = i;
        end
    end
    // Descend towards the hit way and record each turn
    for (int span = num_ways; span > 1; span = span / 2) begin
        half = span / 2;
        if (way >= lo + half) begin
            t[node] = 1'b1;
            lo      = lo + half;
            node    = 2 * node + 2;
        end else begin
            t[node] = 1'b0;
            node    = 2 * node + 1;
        end
    end
    return t;
endfunction

function automatic void ref_evict(
    input  tree_t    tree,
    input  way_vec_t valid_tags,
    input  way_vec_t spm_lock,
    output way_vec_t victim,
    output tree_t    tree_new
);
    way_vec_t    cand;
    int unsigned node;
    int unsigned lo;
    int unsigned half;
    logic        has_lo;
    logic        has_hi;
    logic        go_hi;

    cand = ~valid_tags & ~spm_lock;
    if (cand == '0) begin
        cand = ~spm_lock;
    end
    tree_new = tree;
    node     = 0;
    lo       = 0;
    for (int span = num_ways; span > 1; span = span / 2) begin
        half   = span / 2;
        has_lo = 1'b0;
        has_hi = 1'b0;
        for (int i = 0; i < half; i++) begin
            has_lo = has_lo | cand[lo + i];
            has_hi = has_hi | cand[lo + half + i];
        end
        go_hi          = has_lo ? (has_hi && !tree[node]) : 1'b1;
        tree_new[node] = go_hi;
        if (go_hi) begin
            lo   = lo + half;
            node = 2 * node + 2;
        end else begin
            node = 2 * node + 1;
        end
    end
    victim     = '0;
    victim[lo] = 1'b1;
endfunction

`endif

//--- verif/plru_tb.sv
// Testbench for the tree pseudo-LRU replacement unit
// Random hit and evict traffic with random response back-pressure
// Scoreboard against the reference tree model, watchdog
`timescale 1ns/1ps

module plru_tb
    import plru_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int num_reqs     = 400;
    localparam int limit_cycles = num_reqs * 8 + reset_cycles;

    logic      clk;
    logic      arst_n;
    plru_req_t req;
    logic      req_valid;
    logic      req_ready;
    plru_rsp_t rsp;
    logic      rsp_valid;
    logic      rsp_ready;

    // Testbench copy of every set's tree bits
    tree_t     model_tree [num_sets];
    plru_req_t pending [$];
    plru_rsp_t stall_rsp;
    logic      stall_seen;
    int        ready_pct;
    int        rsp_count;

    `include "plru_ref.svh"

    plru_top DUT (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready)
    );

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run aborted");
    endtask

    function automatic way_vec_t random_ways();
        return way_vec_t'({$urandom, $urandom});
    endfunction

    // Hold the request until the DUT takes it
    task automatic send_request(input plru_req_t r);
        @(negedge clk);
        req       = r;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(limit_cycles * clk_period);
        abort_run("Timeout: the responses stopped before all requests were answered");
    end

    initial begin : ready_drive
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rsp_ready = ($urandom % 100) < ready_pct;
        end
    end

    always @(posedge clk) begin : compare
        plru_req_t r;
        plru_rsp_t exp;
        way_vec_t  exp_way;
        tree_t     exp_tree;
        way_vec_t  free_ways;

        if (arst_n) begin
            // A stalled response and its ready must not move
            if (stall_seen) begin
                assert (rsp_valid && rsp == stall_rsp && !req_ready)
                else report_mismatch("response or req_ready changed during back-pressure");
            end
            stall_seen = rsp_valid && !rsp_ready;
            stall_rsp  = rsp;
            if (req_valid && req_ready) begin
                pending.push_back(req);
            end
            if (rsp_valid && rsp_ready) begin
                assert (pending.size() == 1)
                else abort_run("A response came without an accepted request");
                r = pending.pop_front();
                if (r.op == op_hit) begin
                    exp_way  = r.hit_way;
                    exp_tree = ref_hit(model_tree[r.index], r.hit_way);
                end else begin
                    ref_evict(model_tree[r.index], r.valid_tags, r.spm_lock,
                              exp_way, exp_tree);
                end
                exp.op          = r.op;
                exp.way         = exp_way;
                exp.evict_dirty = (r.op == op_evict) &&
                                  (|(exp_way & r.valid_tags & r.dirty_tags));
                free_ways       = ~r.valid_tags & ~r.spm_lock;
                assert (rsp == exp)
                else report_mismatch($sformatf(
                    "set %0d op %0d way %b dirty %b, expected %b %b",
                    r.index, r.op, rsp.way, rsp.evict_dirty, exp.way, exp.evict_dirty));
                assert (r.op == op_hit || (rsp.way & r.spm_lock) == '0)
                else report_mismatch("a locked way was evicted");
                assert (r.op == op_hit || free_ways == '0 || (rsp.way & free_ways) != '0)
                else report_mismatch("an occupied way was evicted while a free one existed");
                // Zero tree with every way free walks to the top way
                assert (r.op == op_hit || model_tree[r.index] != '0 || free_ways != '1 ||
                        rsp.way[num_ways-1])
                else report_mismatch("the all-zero tree did not evict the top way");
                model_tree[r.index] = exp_tree;
                rsp_count++;
            end
        end
    end

    initial begin : stimulus
        plru_req_t r;

        void'($urandom(32'h7030));
        arst_n     = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        ready_pct  = 75;
        rsp_count  = 0;
        stall_seen = 1'b0;
        foreach (model_tree[s]) begin
            model_tree[s] = '0;
        end
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
        assert (req_ready && !rsp_valid)
        else abort_run("The DUT was not idle after reset");

        for (int i = 0; i < num_reqs; i++) begin
            r.hit_way                      = '0;
            r.hit_way[$urandom % num_ways] = 1'b1;
            r.dirty_tags                   = random_ways();
            r.spm_lock                     = '0;
            r.op = ($urandom % 2 == 0) ? op_evict : op_hit;
            r.index = index_t'($urandom % num_sets);
            if (i < num_sets) begin
                // Untouched sets with all ways free
                r.op         = op_evict;
                r.index      = index_t'(i);
                r.valid_tags = '0;
            end else if (i < 160) begin
                // Many hits on a few full sets
                r.op         = ($urandom % 4 == 0) ? op_evict : op_hit;
                r.index      = index_t'($urandom % 4);
                r.valid_tags = '1;
            end else if (i < 280) begin
                r.valid_tags = random_ways();
            end else begin
                ready_pct  = 40;
                r.spm_lock = random_ways() & random_ways();
                if (&r.spm_lock) begin
                    r.spm_lock[$urandom % num_ways] = 1'b0;
                end
                r.valid_tags = ($urandom % 2 == 0) ? ~r.spm_lock : random_ways();
            end
            send_request(r);
        end
        @(negedge clk);
        req_valid = 1'b0;
        wait (rsp_count == num_reqs);
        @(negedge clk);
        // Back in idle once the last response is taken
        if (pending.size() == 0 && req_ready && !rsp_valid) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("The DUT did not return to idle after the last response");
        end
    end

endmodule

//--- tb.f
+incdir+include
logic/plru_pkg.sv
logic/plru_tree_store.sv
logic/plru_hit_update.sv
logic/plru_victim_select.sv
logic/plru_ctrl.sv
logic/plru_top.sv
verif/plru_tb.sv

//--- Makefile
# Verilator build and run of the pseudo-LRU testbench
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module plru_tb -Mdir $(OBJ_DIR) -o plru_tb

# Exit status of the simulation is the pass or fail result
run: compile
	./$(OBJ_DIR)/plru_tb

clean:
	rm -rf $(OBJ_DIR)
